/* source/uart_cfg.svh */
////////////////////////////////////////////////////////////
// UART transmit configuration
// frame format, transmit FIFO size and baud divider
////////////////////////////////////////////////////////////

`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// frame format
`define dataBits	8	// data bits per frame, sent LSB first
`define stopTicks	16	// one stop bit at 16x oversampling

// transmit FIFO
`define fifoAddrLen	4	// 2^4 = 16 entries

// baud timing
// clocks per oversampling tick, kept small for simulation
// a real part would set this from the system clock and baud rate
`define baudDivisor	4

`endif

/* source/uartPkg.sv */
////////////////////////////////////////////////////////////
// UART transmit types
// vector widths and the transmitter state encoding
////////////////////////////////////////////////////////////

`include "uart_cfg.svh"

package uartPkg;

	typedef logic [`dataBits-1:0] uartByte_t;		// one frame payload
	typedef logic [`fifoAddrLen-1:0] fifoPtr_t;		// wraps with the FIFO depth
	typedef logic [`fifoAddrLen:0] fifoCount_t;		// extra bit so 16 fits

	typedef logic [3:0] tickCount_t;	// 16 ticks per bit
	typedef logic [2:0] bitIndex_t;		// which data bit is on the line

	// transmitter FSM, same order as the classic 4-state UART
	typedef enum logic [1:0] {
		idle	= 2'b00,
		start	= 2'b01,
		data	= 2'b10,
		stop	= 2'b11
	} txState_t;

endpackage

/* source/baudTickGen.sv */
////////////////////////////////////////////////////////////
// Baud tick generator
// one-cycle 16x oversampling ticks every baudDivisor clocks
// realigned to the start of each frame
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "uart_cfg.svh"

module baudTickGen
#(
	parameter int baudDivisor = `baudDivisor
)
(
	input logic clk,
	input logic reset,
	input logic tickRestart,
	output logic sTick
);

	// divider of 1 still needs a 1-bit counter
	localparam int cntLen = (baudDivisor > 1) ? $clog2(baudDivisor) : 1;
	localparam logic [cntLen-1:0] reloadValue = cntLen'(baudDivisor - 1);

	logic [cntLen-1:0] countReg;	// down-counter, tick at zero

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			countReg <= reloadValue;
		else if (tickRestart)
			countReg <= reloadValue;	// first tick baudDivisor clocks after restart
		else if (countReg == '0)
			countReg <= reloadValue;	// wrap
		else
			countReg <= countReg - 1'b1;
	end

	// tick while the counter sits at zero, exactly one cycle per wrap
	assign sTick = (countReg == '0);

	////////////////////////////////////////////////////////////
	// checks

	// ticks never merge into a level unless every clock is a tick
	aTickIsPulse: assert property (@(posedge clk) disable iff (reset)
		(baudDivisor > 1 && sTick) |=> !sTick);

endmodule

/* source/txFifo.sv */
////////////////////////////////////////////////////////////
// Transmit FIFO
// byte queue between the write side and the transmitter
// writes while full are dropped
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "uart_cfg.svh"

module txFifo
	import uartPkg::*;
(
	input logic clk,
	input logic reset,
	input uartByte_t wrData,
	input logic wrEn,
	input logic pop,
	output uartByte_t rdData,
	output logic empty,
	output logic full
);

	localparam int depth = 1 << `fifoAddrLen;
	localparam fifoCount_t depthCount = fifoCount_t'(depth);

	uartByte_t mem [depth];		// storage

	fifoPtr_t wrPtr;		// next slot to fill
	fifoPtr_t rdPtr;		// head entry
	fifoCount_t count;		// entries held

	logic wrAccept;
	logic rdAccept;

	////////////////////////////////////////////////////////////
	// handshake

	assign rdAccept = pop && !empty;
	// a pop in the same cycle frees the slot, so a full FIFO still takes the write
	assign wrAccept = wrEn && (!full || rdAccept);

	////////////////////////////////////////////////////////////
	// storage

	always_ff @(posedge clk)
	begin
		if (wrAccept)
			mem[wrPtr] <= wrData;
	end

	assign rdData = mem[rdPtr];	// head shown combinationally

	////////////////////////////////////////////////////////////
	// pointers and fill count

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (wrAccept)
				wrPtr <= wrPtr + 1'b1;	// wraps at depth
			if (rdAccept)
				rdPtr <= rdPtr + 1'b1;

			if (wrAccept && !rdAccept)
				count <= count + 1'b1;
			else if (rdAccept && !wrAccept)
				count <= count - 1'b1;
			// both or neither, count holds
		end
	end

	assign empty = (count == '0);
	assign full = (count == depthCount);

	////////////////////////////////////////////////////////////
	// checks

	// transmitter only pops when it has seen a byte waiting
	aNoPopWhenEmpty: assert property (@(posedge clk) disable iff (reset)
		pop |-> !empty);

	aCountInRange: assert property (@(posedge clk) disable iff (reset)
		count <= depthCount);

endmodule

/* source/uartTrans.sv */
////////////////////////////////////////////////////////////
// UART transmitter
// idle, start, data, stop FSM at 16 ticks per bit
// pops one byte from the FIFO per frame, sends LSB first
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "uart_cfg.svh"

module uartTrans
	import uartPkg::*;
(
	input logic clk,
	input logic reset,
	input logic sTick,
	input uartByte_t fifoData,
	input logic fifoEmpty,
	output logic pop,
	output logic tickRestart,
	output logic tx,
	output logic busy
);

	localparam tickCount_t lastTick = tickCount_t'(15);	// 16 ticks per bit
	localparam tickCount_t lastStopTick = tickCount_t'(`stopTicks - 1);
	localparam bitIndex_t lastBit = bitIndex_t'(`dataBits - 1);

	txState_t stateReg;
	txState_t stateNext;
	tickCount_t sReg;		// ticks within the current bit
	tickCount_t sNext;
	bitIndex_t nReg;		// data bit on the line
	bitIndex_t nNext;
	uartByte_t bReg;		// shift register, LSB goes out
	uartByte_t bNext;
	logic txReg;			// registered line, no glitches on tx
	logic txNext;
	logic busyReg;
	logic busyNext;

	////////////////////////////////////////////////////////////
	// state registers

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= idle;
			sReg <= '0;
			nReg <= '0;
			txReg <= 1'b1;		// line idles high
			busyReg <= 1'b0;
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			txReg <= txNext;
			busyReg <= busyNext;
		end
	end

	always_ff @(posedge clk)
	begin
		bReg <= bNext;
	end

	////////////////////////////////////////////////////////////
	// next state

	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		txNext = txReg;
		pop = 1'b0;

		case (stateReg)
			idle:
			begin
				txNext = 1'b1;
				if (!fifoEmpty)
				begin
					pop = 1'b1;		// FIFO read strobe
					bNext = fifoData;	// latch on the pop edge, head moves on
					sNext = '0;
					stateNext = start;
				end
			end
			start:
			begin
				txNext = 1'b0;		// start bit
				if (sTick)
				begin
					if (sReg == lastTick)
					begin
						sNext = '0;
						nNext = '0;
						stateNext = data;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			data:
			begin
				txNext = bReg[0];
				if (sTick)
				begin
					if (sReg == lastTick)
					begin
						sNext = '0;
						bNext = bReg >> 1;	// next bit to LSB
						if (nReg == lastBit)
							stateNext = stop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			stop:
			begin
				txNext = 1'b1;
				if (sTick)
				begin
					if (sReg == lastStopTick)
					begin
						sNext = '0;
						stateNext = idle;	// next byte may pop right away
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			default: stateNext = idle;
		endcase
	end

	assign tickRestart = pop;	// bit timing starts at the pop edge

	// busy follows the line one cycle behind the state
	// a back-to-back pop keeps it up across the 1-clock gap
	assign busyNext = (stateReg != idle) || (pop && busyReg);

	assign tx = txReg;
	assign busy = busyReg;

	////////////////////////////////////////////////////////////
	// checks

	aIdleLineHigh: assert property (@(posedge clk) disable iff (reset)
		(stateReg == idle) |-> tx);

	// line register lags the state by one clock
	aStopLineHigh: assert property (@(posedge clk) disable iff (reset)
		(stateReg == stop) |=> tx);

	aPopInIdle: assert property (@(posedge clk) disable iff (reset)
		pop |-> (stateReg == idle));

	aLowReachesLine: assert property (@(posedge clk) disable iff (reset)
		(txNext == 1'b0) |=> !tx);

endmodule

/* source/uartTxTop.sv */
////////////////////////////////////////////////////////////
// UART transmit subsystem
// transmit FIFO, baud tick generator and transmitter
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "uart_cfg.svh"

module uartTxTop
	import uartPkg::*;
(
	input logic clk,
	input logic reset,
	input uartByte_t wrData,
	input logic wrEn,
	output logic full,
	output logic tx,
	output logic busy
);

	uartByte_t fifoData;		// FIFO head
	logic fifoEmpty;
	logic pop;			// transmitter takes the head
	logic tickRestart;		// realign bit timing at frame start
	logic sTick;			// 16x oversampling tick

	txFifo i_txFifo (
		.clk		(clk),
		.reset		(reset),
		.wrData		(wrData),
		.wrEn		(wrEn),
		.pop		(pop),
		.rdData		(fifoData),
		.empty		(fifoEmpty),
		.full		(full)
	);

	baudTickGen #(
		.baudDivisor	(`baudDivisor)
	) i_baudTickGen (
		.clk		(clk),
		.reset		(reset),
		.tickRestart	(tickRestart),
		.sTick		(sTick)
	);

	uartTrans i_uartTrans (
		.clk		(clk),
		.reset		(reset),
		.sTick		(sTick),
		.fifoData	(fifoData),
		.fifoEmpty	(fifoEmpty),
		.pop		(pop),
		.tickRestart	(tickRestart),
		.tx		(tx),
		.busy		(busy)
	);

endmodule

/* tests/uartTxTb.sv */
////////////////////////////////////////////////////////////
// UART transmit testbench
// writes bytes into the FIFO, decodes the serial line and
// checks frame timing, back-pressure and the busy level
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "uart_cfg.svh"

module uartTxTb
	import uartPkg::*;
();

	localparam int bitClocks = 16 * `baudDivisor;		// clocks per start/data bit
	localparam int stopClocks = `stopTicks * `baudDivisor;
	// fall to fall of back-to-back frames, 1-clock gap included
	localparam int frameClocks = bitClocks * (`dataBits + 1) + stopClocks + 1;
	localparam int timeoutCycles = 30000;	// 26 frames of 641 clocks plus idle waits
	localparam int totalFrames = 1 + 8 + 17;	// single, burst, accepted back-pressure writes

	logic clk;
	logic reset;
	uartByte_t wrData;
	logic wrEn;
	logic full;
	logic tx;
	logic busy;

	int cycleCount = 0;		// rising edges since time 0
	int lastFall = -1000000;	// edge of the previous start bit
	int frameCount = 0;
	uartByte_t expBytes[$];		// accepted writes, oldest first
	int expEdges[$];		// write edge of each queued byte

	uartTxTop i_uartTxTop (
		.clk	(clk),
		.reset	(reset),
		.wrData	(wrData),
		.wrEn	(wrEn),
		.full	(full),
		.tx	(tx),
		.busy	(busy)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;	// 10 ns period

	////////////////////////////////////////////////////////////
	// error reporting and run limit

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("Verification failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic reportMismatch(input string signal, input logic [31:0] expected,
		input logic [31:0] actual);
		failRun($sformatf("Fail %s: expected 0x%0h, got 0x%0h", signal, expected, actual));
	endtask

	always @(posedge clk)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= timeoutCycles)
			failRun($sformatf("Timeout: run not finished after %0d cycles", timeoutCycles));
	end

	////////////////////////////////////////////////////////////
	// checks on the outputs, sampled mid-cycle

	aResetOutputs: assert property (@(negedge clk) reset |-> (tx && !busy && !full))
		else reportMismatch("{tx,busy,full} in reset", 32'h4, 32'({tx, busy, full}));

	aResetState: assert property (@(negedge clk)
		reset |-> (i_uartTxTop.i_uartTrans.stateReg == idle))
		else failRun("transmitter FSM is not idle during reset");

	// line stays high whenever the transmitter is not busy
	aQuietLine: assert property (@(negedge clk) disable iff (reset) !busy |-> tx)
		else reportMismatch("tx while not busy", 32'h1, 32'(tx));

	aBusyWithStart: assert property (@(negedge clk) disable iff (reset) $rose(busy) |-> !tx)
		else reportMismatch("tx when busy rises", 32'h0, 32'(tx));

	////////////////////////////////////////////////////////////
	// stimulus helpers

	// called on a falling edge, returns on the next one
	task automatic writeByte(input uartByte_t value);
		wrData = value;
		wrEn = 1'b1;
		if (!full)
		begin
			expBytes.push_back(value);	// accepted on the coming edge
			expEdges.push_back(cycleCount + 1);
		end
		@(negedge clk);
		wrEn = 1'b0;
	endtask

	// drained queue, then a full stop period of high line
	task automatic waitIdle();
		int quiet;
		quiet = 0;
		while (quiet < stopClocks || expBytes.size() != 0)
		begin
			@(negedge clk);
			if (tx === 1'b1 && expBytes.size() == 0)
				quiet++;
			else
				quiet = 0;
		end
		assert (busy === 1'b0) else reportMismatch("busy after drain", 32'h0, 32'(busy));
	endtask

	////////////////////////////////////////////////////////////
	// serial line decoder

	// starts on the first falling edge of a bit, ends on its last
	task automatic watchBit(input int clocks, output logic midValue);
		logic firstValue;
		firstValue = tx;
		midValue = tx;
		for (int k = 0; k < clocks; k++)
		begin
			if (k > 0)
				@(negedge clk);
			if (k == clocks / 2)
				midValue = tx;		// mid-bit sample
			assert (tx === firstValue)
				else reportMismatch("tx within bit", 32'(firstValue), 32'(tx));
			assert (busy === 1'b1) else reportMismatch("busy in frame", 32'h1, 32'(busy));
		end
	endtask

	initial
	begin : lineDecoder
		uartByte_t rebuilt;
		logic midValue;
		int expEdge;
		logic byteWaiting;
		@(negedge reset);
		forever
		begin
			@(negedge clk);
			if (tx === 1'b0)
			begin
				if (expBytes.size() == 0)
					failRun("tx started a frame with no byte waiting to be sent");
				// 2 edges after the write, or 1 clock after the previous stop
				expEdge = expEdges[0] + 2;
				if (lastFall + frameClocks > expEdge)
					expEdge = lastFall + frameClocks;
				assert (cycleCount == expEdge)
					else reportMismatch("start bit edge", expEdge, cycleCount);
				lastFall = cycleCount;
				watchBit(bitClocks, midValue);
				assert (midValue === 1'b0)
					else reportMismatch("tx start bit", 32'h0, 32'(midValue));
				for (int i = 0; i < `dataBits; i++)
				begin
					@(negedge clk);
					watchBit(bitClocks, midValue);
					rebuilt[i] = midValue;	// LSB first
				end
				@(negedge clk);
				watchBit(stopClocks, midValue);
				assert (midValue === 1'b1)
					else reportMismatch("tx stop bit", 32'h1, 32'(midValue));
				assert (rebuilt === expBytes[0])
					else reportMismatch("tx byte", 32'(expBytes[0]), 32'(rebuilt));
				void'(expBytes.pop_front());
				void'(expEdges.pop_front());
				frameCount++;

				// clock after the stop bit, busy holds only for a byte already written
				@(negedge clk);
				byteWaiting = (expEdges.size() != 0) && (expEdges[0] < cycleCount);
				assert (tx === 1'b1)
					else reportMismatch("tx after stop bit", 32'h1, 32'(tx));
				assert (busy === byteWaiting)
					else reportMismatch("busy after stop bit", 32'(byteWaiting),
						32'(busy));
			end
		end
	end

	////////////////////////////////////////////////////////////
	// test sequence

	initial
	begin : stimulus
		int firstEdge;
		reset = 1'b1;
		wrEn = 1'b0;
		wrData = '0;
		void'($urandom(32'he7ce_b884));		// one seed for the whole run
		repeat (5) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		assert ({tx, busy, full} === 3'b100)
			else reportMismatch("{tx,busy,full} after reset", 32'h4, 32'({tx, busy, full}));

		// single frame into the idle DUT
		writeByte(8'h4b);
		waitIdle();

		// burst, frames back to back
		for (int i = 0; i < 8; i++)
			writeByte(uartByte_t'($urandom));
		waitIdle();

		// overflow, first byte popped at once so 16 more fill the FIFO
		firstEdge = cycleCount + 1;
		for (int i = 0; i < 20; i++)
		begin
			writeByte(uartByte_t'($urandom));
			assert (full === (i >= 16))
				else reportMismatch("full after write", 32'(i >= 16), 32'(full));
		end
		while (full)
			@(negedge clk);
		// entry freed by the pop at the end of the first frame
		assert (cycleCount == firstEdge + 2 + frameClocks - 1)
			else reportMismatch("full falling edge", firstEdge + 2 + frameClocks - 1,
				cycleCount);
		waitIdle();

		if (expBytes.size() == 0 && busy === 1'b0 && frameCount == totalFrames)
		begin
			$display("Verification passed");
			$finish;
		end
		else
			failRun($sformatf("run ended with %0d frames and %0d bytes still expected",
				frameCount, expBytes.size()));
	end

endmodule

/* files.f */
+incdir+source
source/uartPkg.sv
source/baudTickGen.sv
source/txFifo.sv
source/uartTrans.sv
source/uartTxTop.sv
tests/uartTxTb.sv

/* run.sh */
#!/bin/sh
# compile and run the UART transmit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f files.f --top-module uartTxTb -o uartTxSim || { echo "build failed"; exit 1; }

# pass only when the simulation printed the pass line
simOut=$(./obj_dir/uartTxSim 2>&1)
echo "$simOut"
echo "$simOut" | grep -qx "Verification passed" && echo "PASS" || { echo "FAIL"; exit 1; }
